// File: include/axi_lite_defines.svh
`ifndef AXI_LITE_DEFINES_SVH
`define AXI_LITE_DEFINES_SVH

// --------------------
// Bus widths
// --------------------

// Host side and bus side are both fixed at 32 bits
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// One strobe bit per byte lane of the data bus
`define AXI_STRB_W (`AXI_DATA_W / 8)

// --------------------
// Fixed protection values
// --------------------

// Writes go out as unprivileged, secure, data accesses
`define AXI_WRITE_PROT 3'b000

// Reads are marked privileged, everything else the same as writes
`define AXI_READ_PROT 3'b001

`endif

// File: src/axi_lite_pkg.sv
`include "axi_lite_defines.svh"

package axi_lite_pkg;

	// --------------------
	// Response codes
	// --------------------

	// Encodings follow the AXI4-Lite BRESP and RRESP fields
	// Bit 1 high means the transfer failed (SLVERR or DECERR)
	typedef enum logic [1:0]
	{
		resp_okay   = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} axi_resp_e;

	// --------------------
	// Payload fields
	// --------------------

	// AWPROT and ARPROT carry privilege, security and instruction/data bits
	typedef logic [2:0] axi_prot_t;

	// Address and data vectors, sized from the shared width macros
	typedef logic [`AXI_ADDR_W-1:0] addr_t;
	typedef logic [`AXI_DATA_W-1:0] data_t;

endpackage

// File: src/host_cmd_pkg.sv
package host_cmd_pkg;

	// --------------------
	// Host command decode
	// --------------------

	// Result of decoding the wr and rd strobes in one cycle
	// A write wins when both strobes are high together
	typedef enum logic [1:0]
	{
		op_none,
		op_write,
		op_read
	} host_op_e;

	// --------------------
	// Command unit FSM
	// --------------------

	// Idle accepts a request, the other two wait for the engine's done
	typedef enum logic [1:0]
	{
		st_idle,
		st_write,
		st_read
	} cmd_state_e;

endpackage

// File: src/chan_ctrl_if.sv
interface chan_ctrl_if;
	import axi_lite_pkg::*;

	// One-cycle strobe that launches a transaction on the engine
	logic start;

	// Target address, held stable for the whole transaction
	addr_t addr;

	// Write payload, the read engine leaves it alone
	data_t wdata;

	// One-cycle strobe, exactly one per start
	logic done;

	// Response error, only meaningful while done is high
	logic resp_err;

	// The command unit launches and the engine reports back
	modport ctrl
	(
		output start,
		output addr,
		output wdata,
		input  done,
		input  resp_err
	);

	// Seen from the side of a channel engine
	modport engine
	(
		input  start,
		input  addr,
		input  wdata,
		output done,
		output resp_err
	);

endinterface

// File: src/host_cmd_unit.sv
module host_cmd_unit
(
	input  logic                M_AXI_ACLK,
	input  logic                M_AXI_ARESETN,
	input  axi_lite_pkg::addr_t addr,
	input  axi_lite_pkg::data_t data_in,
	input  logic                wr,
	input  logic                rd,
	chan_ctrl_if.ctrl           wr_ch,
	chan_ctrl_if.ctrl           rd_ch,
	output logic                busy,
	output logic                err
);
	import axi_lite_pkg::*;
	import host_cmd_pkg::*;

	cmd_state_e state;
	host_op_e   op;

	// Latched request payload, shared by both engines
	addr_t addr_q;
	data_t data_q;

	// Registered start strobes toward the engines
	logic wr_start;
	logic rd_start;

	// --------------------
	// Request decode
	// --------------------

	// Only an idle unit takes a request, anything else is dropped
	// The write strobe takes priority over the read strobe
	always_comb
	begin
		op = op_none;
		if (state == st_idle)
		begin
			if (wr)
				op = op_write;
			else if (rd)
				op = op_read;
		end
	end

	// High in the request cycle itself and through the done cycle
	assign busy = (state != st_idle) | wr | rd;

	// --------------------
	// Command FSM
	// --------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			state    <= st_idle;
			wr_start <= 1'b0;
			rd_start <= 1'b0;
			err      <= 1'b0;
		end
		else
		begin
			// Start strobes last a single cycle
			wr_start <= 1'b0;
			rd_start <= 1'b0;
			case (state)
				st_idle:
				begin
					// An accepted command clears the error of the one before
					if (op == op_write)
					begin
						state    <= st_write;
						wr_start <= 1'b1;
						err      <= 1'b0;
					end
					else if (op == op_read)
					begin
						state    <= st_read;
						rd_start <= 1'b1;
						err      <= 1'b0;
					end
				end
				st_write:
				begin
					if (wr_ch.done)
					begin
						state <= st_idle;
						// Error stays set until the next accepted command
						if (wr_ch.resp_err)
							err <= 1'b1;
					end
				end
				st_read:
				begin
					if (rd_ch.done)
					begin
						state <= st_idle;
						if (rd_ch.resp_err)
							err <= 1'b1;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// Payload is captured at the same edge that issues start
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (op != op_none)
			addr_q <= addr;
		if (op == op_write)
			data_q <= data_in;
	end

	// --------------------
	// Engine handoff
	// --------------------

	assign wr_ch.start = wr_start;
	assign wr_ch.addr  = addr_q;
	assign wr_ch.wdata = data_q;

	// The read engine has no use for the write payload
	assign rd_ch.start = rd_start;
	assign rd_ch.addr  = addr_q;
	assign rd_ch.wdata = data_q;

endmodule

// File: src/axi_write_engine.sv
`include "axi_lite_defines.svh"

module axi_write_engine
(
	input  logic                    M_AXI_ACLK,
	input  logic                    M_AXI_ARESETN,
	input  logic                    AWREADY,
	input  logic                    WREADY,
	input  axi_lite_pkg::axi_resp_e BRESP,
	input  logic                    BVALID,
	chan_ctrl_if.engine             ch,
	output axi_lite_pkg::addr_t     AWADDR,
	output axi_lite_pkg::axi_prot_t AWPROT,
	output logic                    AWVALID,
	output axi_lite_pkg::data_t     WDATA,
	output logic [`AXI_STRB_W-1:0]  WSTRB,
	output logic                    WVALID,
	output logic                    BREADY
);
	import axi_lite_pkg::*;

	// Address and data held for the life of the write
	addr_t awaddr_q;
	data_t wdata_q;

	logic awvalid_q;
	logic wvalid_q;
	logic bready_q;

	// Set while the B response of the current write is still owed
	logic resp_pend;

	// B handshake, which also ends the write
	logic b_hs;

	assign b_hs = BVALID & bready_q;

	// --------------------
	// Payload capture
	// --------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (ch.start)
		begin
			awaddr_q <= ch.addr;
			wdata_q  <= ch.wdata;
		end
	end

	// --------------------
	// AW and W channels
	// --------------------

	// Both valids go up together one cycle after start
	// Each one falls on its own handshake, so the slave may take them in any order
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
		end
		else
		begin
			if (ch.start)
				awvalid_q <= 1'b1;
			else if (AWREADY && awvalid_q)
				awvalid_q <= 1'b0;

			if (ch.start)
				wvalid_q <= 1'b1;
			else if (WREADY && wvalid_q)
				wvalid_q <= 1'b0;
		end
	end

	// --------------------
	// B channel
	// --------------------

	// BREADY is a registered acknowledge, high for one cycle after BVALID shows up
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			bready_q  <= 1'b0;
			resp_pend <= 1'b0;
		end
		else
		begin
			bready_q <= BVALID & ~bready_q & resp_pend;
			if (ch.start)
				resp_pend <= 1'b1;
			else if (b_hs)
				resp_pend <= 1'b0;
		end
	end

	// The write counts as finished only once the slave has committed it
	assign ch.done     = b_hs;
	// SLVERR and DECERR both have bit 1 set
	assign ch.resp_err = BRESP[1];

	// --------------------
	// Bus outputs
	// --------------------

	assign AWADDR  = awaddr_q;
	assign AWPROT  = `AXI_WRITE_PROT;
	assign AWVALID = awvalid_q;
	assign WDATA   = wdata_q;
	// Every byte lane is written
	assign WSTRB   = {`AXI_STRB_W{1'b1}};
	assign WVALID  = wvalid_q;
	assign BREADY  = bready_q;

endmodule

// File: src/axi_read_engine.sv
`include "axi_lite_defines.svh"

module axi_read_engine
(
	input  logic                    M_AXI_ACLK,
	input  logic                    M_AXI_ARESETN,
	input  logic                    ARREADY,
	input  axi_lite_pkg::data_t     RDATA,
	input  axi_lite_pkg::axi_resp_e RRESP,
	input  logic                    RVALID,
	chan_ctrl_if.engine             ch,
	output axi_lite_pkg::addr_t     ARADDR,
	output axi_lite_pkg::axi_prot_t ARPROT,
	output logic                    ARVALID,
	output logic                    RREADY,
	output axi_lite_pkg::data_t     data_out
);
	import axi_lite_pkg::*;

	// Read address held until ARREADY
	addr_t araddr_q;

	logic arvalid_q;
	logic rready_q;

	// Set while the R beat of the current read is still owed
	logic data_pend;

	// R handshake, which also ends the read
	logic r_hs;

	assign r_hs = RVALID & rready_q;

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (ch.start)
			araddr_q <= ch.addr;
	end

	// --------------------
	// AR and R channels
	// --------------------

	// ARVALID rises one cycle after start and holds until the slave takes it
	// RREADY is a one-cycle registered acknowledge after RVALID is seen
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			arvalid_q <= 1'b0;
			rready_q  <= 1'b0;
			data_pend <= 1'b0;
		end
		else
		begin
			if (ch.start)
				arvalid_q <= 1'b1;
			else if (ARREADY && arvalid_q)
				arvalid_q <= 1'b0;

			rready_q <= RVALID & ~rready_q & data_pend;

			if (ch.start)
				data_pend <= 1'b1;
			else if (r_hs)
				data_pend <= 1'b0;
		end
	end

	// --------------------
	// Host read data
	// --------------------

	// Old data is wiped as soon as a new read starts, then RDATA lands at the handshake
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
			data_out <= '0;
		else if (ch.start)
			data_out <= '0;
		else if (r_hs)
			data_out <= RDATA;
	end

	assign ch.done     = r_hs;
	// Bit 1 of RRESP flags SLVERR or DECERR
	assign ch.resp_err = RRESP[1];

	assign ARADDR  = araddr_q;
	assign ARPROT  = `AXI_READ_PROT;
	assign ARVALID = arvalid_q;
	assign RREADY  = rready_q;

endmodule

// File: src/axi_lite_master.sv
`include "axi_lite_defines.svh"

module axi_lite_master
(
	input  logic                    M_AXI_ACLK,
	input  logic                    M_AXI_ARESETN,

	// Host side
	input  axi_lite_pkg::addr_t     addr,
	input  axi_lite_pkg::data_t     data_in,
	input  logic                    wr,
	input  logic                    rd,
	output axi_lite_pkg::data_t     data_out,
	output logic                    busy,
	output logic                    err,

	// Write address channel
	output axi_lite_pkg::addr_t     M_AXI_AWADDR,
	output axi_lite_pkg::axi_prot_t M_AXI_AWPROT,
	output logic                    M_AXI_AWVALID,
	input  logic                    M_AXI_AWREADY,

	// Write data channel
	output axi_lite_pkg::data_t     M_AXI_WDATA,
	output logic [`AXI_STRB_W-1:0]  M_AXI_WSTRB,
	output logic                    M_AXI_WVALID,
	input  logic                    M_AXI_WREADY,

	// Write response channel
	input  axi_lite_pkg::axi_resp_e M_AXI_BRESP,
	input  logic                    M_AXI_BVALID,
	output logic                    M_AXI_BREADY,

	// Read address channel
	output axi_lite_pkg::addr_t     M_AXI_ARADDR,
	output axi_lite_pkg::axi_prot_t M_AXI_ARPROT,
	output logic                    M_AXI_ARVALID,
	input  logic                    M_AXI_ARREADY,

	// Read data channel
	input  axi_lite_pkg::data_t     M_AXI_RDATA,
	input  axi_lite_pkg::axi_resp_e M_AXI_RRESP,
	input  logic                    M_AXI_RVALID,
	output logic                    M_AXI_RREADY
);

	// --------------------
	// Control links
	// --------------------

	// One link per engine, both driven by the command unit
	chan_ctrl_if wr_ch ();
	chan_ctrl_if rd_ch ();

	// Accepts host strobes and launches one engine at a time
	host_cmd_unit u_cmd
	(
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.addr          (addr),
		.data_in       (data_in),
		.wr            (wr),
		.rd            (rd),
		.wr_ch         (wr_ch.ctrl),
		.rd_ch         (rd_ch.ctrl),
		.busy          (busy),
		.err           (err)
	);

	// --------------------
	// Channel engines
	// --------------------

	axi_write_engine u_wr
	(
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.AWREADY       (M_AXI_AWREADY),
		.WREADY        (M_AXI_WREADY),
		.BRESP         (M_AXI_BRESP),
		.BVALID        (M_AXI_BVALID),
		.ch            (wr_ch.engine),
		.AWADDR        (M_AXI_AWADDR),
		.AWPROT        (M_AXI_AWPROT),
		.AWVALID       (M_AXI_AWVALID),
		.WDATA         (M_AXI_WDATA),
		.WSTRB         (M_AXI_WSTRB),
		.WVALID        (M_AXI_WVALID),
		.BREADY        (M_AXI_BREADY)
	);

	// The read engine also owns the host data_out register
	axi_read_engine u_rd
	(
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.ARREADY       (M_AXI_ARREADY),
		.RDATA         (M_AXI_RDATA),
		.RRESP         (M_AXI_RRESP),
		.RVALID        (M_AXI_RVALID),
		.ch            (rd_ch.engine),
		.ARADDR        (M_AXI_ARADDR),
		.ARPROT        (M_AXI_ARPROT),
		.ARVALID       (M_AXI_ARVALID),
		.RREADY        (M_AXI_RREADY),
		.data_out      (data_out)
	);

endmodule

// File: verification/axi_lite_slave_model.sv
module axi_lite_slave_model
#(
	parameter logic [31:0] lcg_seed = 32'h407fa90f
)
(
	input  logic                    M_AXI_ACLK,
	input  logic                    M_AXI_ARESETN,
	input  axi_lite_pkg::addr_t     AWADDR,
	input  logic                    AWVALID,
	output logic                    AWREADY,
	input  axi_lite_pkg::data_t     WDATA,
	input  logic                    WVALID,
	output logic                    WREADY,
	output axi_lite_pkg::axi_resp_e BRESP,
	output logic                    BVALID,
	input  logic                    BREADY,
	input  axi_lite_pkg::addr_t     ARADDR,
	input  logic                    ARVALID,
	output logic                    ARREADY,
	output axi_lite_pkg::data_t     RDATA,
	output axi_lite_pkg::axi_resp_e RRESP,
	output logic                    RVALID,
	input  logic                    RREADY
);
	import axi_lite_pkg::*;

	// Any address with this bit set answers with SLVERR
	localparam int err_bit = 31;

	data_t mem [0:63];

	// Generator state, only touched by the clocked block below
	logic [31:0] lcg_state;

	// Remaining wait cycles before each channel responds
	logic [1:0] aw_dly;
	logic [1:0] w_dly;
	logic [1:0] b_dly;
	logic [1:0] ar_dly;
	logic [1:0] r_dly;

	// Captured request halves
	logic  aw_got;
	logic  w_got;
	logic  ar_got;
	addr_t aw_addr_q;
	addr_t ar_addr_q;
	data_t w_data_q;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Each word starts out holding its own byte address under a marker
	initial
	begin
		for (int i = 0; i < 64; i++)
			mem[i] = 32'h5a5a_0000 | (i << 2);
	end

	// --------------------
	// Channel responder
	// --------------------

	always @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			lcg_state = lcg_seed;
			{AWREADY, WREADY, ARREADY, BVALID, RVALID} <= '0;
			{aw_got, w_got, ar_got} <= '0;
			{aw_dly, w_dly, b_dly, ar_dly, r_dly} <= '0;
			BRESP <= resp_okay;
			RRESP <= resp_okay;
			RDATA <= '0;
		end
		else
		begin
			// Ready lines are single-cycle pulses
			AWREADY <= 1'b0;
			WREADY  <= 1'b0;
			ARREADY <= 1'b0;

			if (AWVALID && !AWREADY && !aw_got)
			begin
				if (aw_dly == 2'd0)
					AWREADY <= 1'b1;
				else
					aw_dly <= aw_dly - 2'd1;
			end
			if (AWVALID && AWREADY)
			begin
				aw_got    <= 1'b1;
				aw_addr_q <= AWADDR;
				lcg_state = lcg_next(lcg_state);
				aw_dly    <= lcg_state[31:30];
			end

			if (WVALID && !WREADY && !w_got)
			begin
				if (w_dly == 2'd0)
					WREADY <= 1'b1;
				else
					w_dly <= w_dly - 2'd1;
			end
			if (WVALID && WREADY)
			begin
				w_got    <= 1'b1;
				w_data_q <= WDATA;
				lcg_state = lcg_next(lcg_state);
				w_dly    <= lcg_state[31:30];
			end

			// The write commits only once both halves are in
			if (aw_got && w_got && !BVALID)
			begin
				if (b_dly == 2'd0)
				begin
					BVALID <= 1'b1;
					aw_got <= 1'b0;
					w_got  <= 1'b0;
					if (aw_addr_q[err_bit])
						BRESP <= resp_slverr;
					else
					begin
						BRESP <= resp_okay;
						mem[aw_addr_q[7:2]] <= w_data_q;
					end
					lcg_state = lcg_next(lcg_state);
					b_dly <= lcg_state[31:30];
				end
				else
					b_dly <= b_dly - 2'd1;
			end
			if (BVALID && BREADY)
				BVALID <= 1'b0;

			if (ARVALID && !ARREADY && !ar_got)
			begin
				if (ar_dly == 2'd0)
					ARREADY <= 1'b1;
				else
					ar_dly <= ar_dly - 2'd1;
			end
			if (ARVALID && ARREADY)
			begin
				ar_got    <= 1'b1;
				ar_addr_q <= ARADDR;
				lcg_state = lcg_next(lcg_state);
				ar_dly    <= lcg_state[31:30];
			end

			// Error reads return zero data
			if (ar_got && !RVALID)
			begin
				if (r_dly == 2'd0)
				begin
					RVALID <= 1'b1;
					ar_got <= 1'b0;
					RDATA  <= ar_addr_q[err_bit] ? '0 : mem[ar_addr_q[7:2]];
					RRESP  <= ar_addr_q[err_bit] ? resp_slverr : resp_okay;
					lcg_state = lcg_next(lcg_state);
					r_dly  <= lcg_state[31:30];
				end
				else
					r_dly <= r_dly - 2'd1;
			end
			if (RVALID && RREADY)
				RVALID <= 1'b0;
		end
	end

endmodule

// File: verification/tb_axi_lite_master.sv
`include "axi_lite_defines.svh"

module tb_axi_lite_master;
	import axi_lite_pkg::*;

	localparam int timeout_cycles = 200;
	localparam int max_vecs       = 32;

	logic  M_AXI_ACLK;
	logic  M_AXI_ARESETN;
	addr_t addr;
	data_t data_in;
	logic  wr;
	logic  rd;
	data_t data_out;
	logic  busy;
	logic  err;

	addr_t                   M_AXI_AWADDR;
	axi_prot_t               M_AXI_AWPROT;
	logic                    M_AXI_AWVALID;
	logic                    M_AXI_AWREADY;
	data_t                   M_AXI_WDATA;
	logic [`AXI_STRB_W-1:0]  M_AXI_WSTRB;
	logic                    M_AXI_WVALID;
	logic                    M_AXI_WREADY;
	axi_resp_e               M_AXI_BRESP;
	logic                    M_AXI_BVALID;
	logic                    M_AXI_BREADY;
	addr_t                   M_AXI_ARADDR;
	axi_prot_t               M_AXI_ARPROT;
	logic                    M_AXI_ARVALID;
	logic                    M_AXI_ARREADY;
	data_t                   M_AXI_RDATA;
	axi_resp_e               M_AXI_RRESP;
	logic                    M_AXI_RVALID;
	logic                    M_AXI_RREADY;

	// Each vector takes five words in the order op, address, write data, expected data and err
	logic [31:0] vecs [0:5*max_vecs-1];

	int tests_run;
	int tests_failed;
	int vec_idx;
	bit timed_out;

	// Count of completed B and R handshakes seen on the bus
	int resp_seen;

	// First mismatch of the test in progress
	bit          test_bad;
	string       bad_what;
	logic [31:0] bad_exp;
	logic [31:0] bad_act;

	// First fixed-field violation seen by the bus monitor
	int          field_errs;
	string       field_what;
	logic [31:0] field_exp;
	logic [31:0] field_act;

	initial
		M_AXI_ACLK = 1'b0;
	always #20 M_AXI_ACLK = ~M_AXI_ACLK;

	axi_lite_master uut
	(
		.M_AXI_ACLK (M_AXI_ACLK), .M_AXI_ARESETN (M_AXI_ARESETN),
		.addr (addr), .data_in (data_in), .wr (wr), .rd (rd),
		.data_out (data_out), .busy (busy), .err (err),
		.M_AXI_AWADDR (M_AXI_AWADDR), .M_AXI_AWPROT (M_AXI_AWPROT),
		.M_AXI_AWVALID (M_AXI_AWVALID), .M_AXI_AWREADY (M_AXI_AWREADY),
		.M_AXI_WDATA (M_AXI_WDATA), .M_AXI_WSTRB (M_AXI_WSTRB),
		.M_AXI_WVALID (M_AXI_WVALID), .M_AXI_WREADY (M_AXI_WREADY),
		.M_AXI_BRESP (M_AXI_BRESP), .M_AXI_BVALID (M_AXI_BVALID),
		.M_AXI_BREADY (M_AXI_BREADY),
		.M_AXI_ARADDR (M_AXI_ARADDR), .M_AXI_ARPROT (M_AXI_ARPROT),
		.M_AXI_ARVALID (M_AXI_ARVALID), .M_AXI_ARREADY (M_AXI_ARREADY),
		.M_AXI_RDATA (M_AXI_RDATA), .M_AXI_RRESP (M_AXI_RRESP),
		.M_AXI_RVALID (M_AXI_RVALID), .M_AXI_RREADY (M_AXI_RREADY)
	);

	axi_lite_slave_model u_slave
	(
		.M_AXI_ACLK (M_AXI_ACLK), .M_AXI_ARESETN (M_AXI_ARESETN),
		.AWADDR (M_AXI_AWADDR), .AWVALID (M_AXI_AWVALID), .AWREADY (M_AXI_AWREADY),
		.WDATA (M_AXI_WDATA), .WVALID (M_AXI_WVALID), .WREADY (M_AXI_WREADY),
		.BRESP (M_AXI_BRESP), .BVALID (M_AXI_BVALID), .BREADY (M_AXI_BREADY),
		.ARADDR (M_AXI_ARADDR), .ARVALID (M_AXI_ARVALID), .ARREADY (M_AXI_ARREADY),
		.RDATA (M_AXI_RDATA), .RRESP (M_AXI_RRESP), .RVALID (M_AXI_RVALID),
		.RREADY (M_AXI_RREADY)
	);

	// --------------------
	// Helpers
	// --------------------

	task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (!test_bad)
		begin
			bad_what = what;
			bad_exp  = exp;
			bad_act  = act;
		end
		test_bad = 1'b1;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (test_bad)
		begin
			tests_failed++;
			$display("FAIL %s %s expected %h actual %h", name, bad_what, bad_exp, bad_act);
		end
		else
			$display("ok   %s", name);
		test_bad = 1'b0;
	endtask

	task automatic note_field(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (field_errs == 0)
		begin
			field_what = what;
			field_exp  = exp;
			field_act  = act;
		end
		field_errs++;
	endtask

	function automatic string op_label(input int op);
		case (op)
			1: return "write";
			2: return "read";
			3: return "write_and_read";
			4: return "write_with_stray";
			default: return "unknown";
		endcase
	endfunction

	// Polls busy on falling edges until it drops or the limit runs out
	task automatic wait_idle(input string name);
		int cycles;
		cycles = 0;
		while (busy !== 1'b0 && cycles < timeout_cycles)
		begin
			@(negedge M_AXI_ACLK);
			cycles++;
		end
		if (busy !== 1'b0)
		begin
			timed_out = 1'b1;
			$display("%s: busy never went low within %0d cycles", name, timeout_cycles);
		end
	endtask

	// --------------------
	// Bus monitor
	// --------------------

	// Fixed fields are checked on every cycle a valid is up
	always @(posedge M_AXI_ACLK)
	begin
		if (M_AXI_ARESETN)
		begin
			if (M_AXI_AWVALID && M_AXI_WSTRB !== 4'hf)
				note_field("WSTRB", 32'hf, M_AXI_WSTRB);
			if (M_AXI_AWVALID && M_AXI_AWPROT !== 3'b000)
				note_field("AWPROT", 32'h0, M_AXI_AWPROT);
			if (M_AXI_ARVALID && M_AXI_ARPROT !== 3'b001)
				note_field("ARPROT", 32'h1, M_AXI_ARPROT);
			if ((M_AXI_BVALID && M_AXI_BREADY) || (M_AXI_RVALID && M_AXI_RREADY))
				resp_seen <= resp_seen + 1;
		end
	end

	// --------------------
	// One host operation
	// --------------------

	task automatic run_vector(input int idx, input int op, input logic [31:0] a,
		input logic [31:0] wdata, input logic [31:0] exp_data, input logic [31:0] exp_err);
		string name;
		int    resp_before;
		name        = $sformatf("vec%0d_%s", idx, op_label(op));
		resp_before = resp_seen;

		@(posedge M_AXI_ACLK);
		addr    <= a;
		data_in <= wdata;
		wr      <= (op != 2);
		rd      <= (op == 2 || op == 3);
		@(negedge M_AXI_ACLK);
		if (busy !== 1'b1)
			mismatch("busy_in_request_cycle", 32'h1, busy);

		// Op 4 repeats the write with inverted data while the unit is busy
		@(posedge M_AXI_ACLK);
		wr      <= (op == 4);
		rd      <= 1'b0;
		data_in <= ~wdata;
		// A stray read follows one cycle later and must not start a second transaction
		@(posedge M_AXI_ACLK);
		wr <= 1'b0;
		rd <= (op == 4);
		@(negedge M_AXI_ACLK);
		if (op == 2 && data_out !== '0)
			mismatch("data_out_cleared", 32'h0, data_out);
		@(posedge M_AXI_ACLK);
		rd <= 1'b0;

		wait_idle(name);
		if (timed_out)
		begin
			tests_run++;
			tests_failed++;
		end
		else
		begin
			// Exactly one bus transaction per accepted request
			if (resp_seen - resp_before != 1)
				mismatch("completions", 32'h1, resp_seen - resp_before);
			if (err !== exp_err[0])
				mismatch("err", exp_err, err);
			if (op == 2 && data_out !== exp_data)
				mismatch("data_out", exp_data, data_out);
			close_test(name);
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial
	begin
		M_AXI_ARESETN = 1'b0;
		addr          = '0;
		data_in       = '0;
		wr            = 1'b0;
		rd            = 1'b0;
		tests_run     = 0;
		tests_failed  = 0;
		timed_out     = 1'b0;
		resp_seen     = 0;
		test_bad      = 1'b0;
		field_errs    = 0;
		$readmemh("verification/axi_lite_vectors.txt", vecs);

		repeat (8) @(posedge M_AXI_ACLK);
		M_AXI_ARESETN <= 1'b1;
		@(negedge M_AXI_ACLK);

		// Every status, valid and ready output must come out of reset low
		if ({busy, err, M_AXI_AWVALID, M_AXI_WVALID, M_AXI_BREADY,
			M_AXI_ARVALID, M_AXI_RREADY} !== 7'b0)
			mismatch("control_bits", 32'h0, {busy, err, M_AXI_AWVALID, M_AXI_WVALID,
				M_AXI_BREADY, M_AXI_ARVALID, M_AXI_RREADY});
		if (data_out !== '0)
			mismatch("data_out", 32'h0, data_out);
		close_test("reset");

		// The list ends at the first line whose op is not 1 to 4
		vec_idx = 0;
		while (!timed_out && vec_idx < max_vecs &&
			vecs[5*vec_idx] >= 1 && vecs[5*vec_idx] <= 4)
		begin
			run_vector(vec_idx, vecs[5*vec_idx], vecs[5*vec_idx+1], vecs[5*vec_idx+2],
				vecs[5*vec_idx+3], vecs[5*vec_idx+4]);
			vec_idx++;
		end
		if (vec_idx == 0)
		begin
			$display("no vectors were read from the vector file");
			tests_failed++;
		end

		if (!timed_out)
		begin
			if (field_errs != 0)
				mismatch(field_what, field_exp, field_act);
			close_test("fixed_fields");
		end

		$display("tests %0d passed %0d failed %0d", tests_run, tests_run - tests_failed,
			tests_failed);
		if (tests_failed == 0 && !timed_out)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: sources.f
+incdir+include
src/axi_lite_pkg.sv
src/host_cmd_pkg.sv
src/chan_ctrl_if.sv
src/host_cmd_unit.sv
src/axi_write_engine.sv
src/axi_read_engine.sv
src/axi_lite_master.sv
verification/axi_lite_slave_model.sv
verification/tb_axi_lite_master.sv

// File: Bender.yml
package:
  name: axi_lite_master

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/axi_lite_pkg.sv
      - src/host_cmd_pkg.sv
      - src/chan_ctrl_if.sv
      - src/host_cmd_unit.sv
      - src/axi_write_engine.sv
      - src/axi_read_engine.sv
      - src/axi_lite_master.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/axi_lite_slave_model.sv
      - verification/tb_axi_lite_master.sv

// File: verification/axi_lite_vectors.txt
// op addr wdata exp_data exp_err, all hex
// op 1 write, 2 read, 3 write and read together, 4 write plus a stray write while busy
1 00000000 11111111 00000000 0
1 00000004 22222222 00000000 0
1 000000fc cafef00d 00000000 0
2 00000000 00000000 11111111 0
2 00000004 00000000 22222222 0
2 000000fc 00000000 cafef00d 0
1 80000010 deadbeef 00000000 1
2 00000010 00000000 5a5a0010 0
2 80000020 00000000 00000000 1
1 00000020 0badc0de 00000000 0
4 00000020 12345678 00000000 0
2 00000020 00000000 12345678 0
3 00000030 a5a5a5a5 00000000 0
2 00000030 00000000 a5a5a5a5 0
2 00000008 00000000 5a5a0008 0
0 00000000 00000000 00000000 0
